/* test/secded_stimulus.txt */
// columns: mode, info word, expected codeword, all hex
// last line is an end marker with mode ff
0 0000000 00000000
1 0000000 00000000
2 0000000 00000000
0 000000f 000000ff
1 00007ff 0000ffff
2 3ffffff ffffffff
3 3ffffff 00000000
// single set info bits
0 0000001 0000001b
1 0000001 00000033
2 0000001 00000063
0 0000005 00000055
1 0000400 0000801f
2 2000000 8000001f
0 000000a 000000aa
1 00002a5 000054ad
2 0000800 00020031
3 1234567 00000000
// upper info bits set, same words as the clean vectors
0 3fffff5 00000055
1 3fff801 00000033
2 1234567 48d159f3
0 3ffffff 000000ff
1 3ffffff 0000ffff
3 0000001 00000000
0 0000000 00000000
ff 0000000 00000000

/* sources.f */
+incdir+common
common/secded_types_pkg.sv
common/secded_code_pkg.sv
encoder/enc_check_stage.sv
encoder/enc_parity_stage.sv
design/secded_encoder_top.sv
test/secded_encoder_properties.sv
test/secded_encoder_tb.sv

/* Makefile */
TOP := secded_encoder_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f sources.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

/* test/secded_encoder_tb.sv */
`default_nettype none

// testbench for the secded encoder with vectors from the stimulus file
module secded_encoder_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import secded_types_pkg::*;

    localparam int NUM_VEC        = 24;
    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_VEC + RESET_CYCLES + 10;
    localparam int MEM_WORDS      = 3 * (NUM_VEC + 1);  // three words a line plus end marker
    localparam int END_MARK       = 'hff;               // mode word of the last line

    logic      clk;
    logic      rst;
    info_t     info_in;
    mode_t     mode;
    codeword_t code_out;

    logic [31:0] vec_mem [0:MEM_WORDS-1];  // mode, info, codeword per vector
    codeword_t   exp_q [$];                // words still inside the pipe
    int          cycle_cnt = 0;

    secded_encoder_top dut0 (
        .clk      (clk),
        .rst      (rst),
        .info_in  (info_in),
        .mode     (mode),
        .code_out (code_out)
    );

    always #50 clk = ~clk;  // 100 ns period

    // hard stop in case the main sequence gets stuck
    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run still going after %0d cycles", TIMEOUT_CYCLES);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    task automatic compare_code_out(input codeword_t expected, input string what);
        assert (code_out === expected) else begin
            $display("ERROR: code_out expected %h actual %h at %s", expected, code_out, what);
            $display("Checks failed");
            $fatal(1, "code_out mismatch");
        end
    endtask

    // drive one vector and queue its codeword
    task automatic apply_vector(input int idx);
        mode    = mode_t'(vec_mem[3*idx]);
        info_in = info_t'(vec_mem[3*idx+1]);
        exp_q.push_back(codeword_t'(vec_mem[3*idx+2]));
    endtask

    initial begin
        clk     = 1'b0;
        rst     = 1'b1;
        mode    = MODE_32_26;  // busy inputs during reset
        info_in = '1;          // output must stay clear regardless

        $readmemh("test/secded_stimulus.txt", vec_mem);
        assert (vec_mem[3*NUM_VEC] == END_MARK) else begin
            $display("stimulus file does not hold exactly %0d vectors", NUM_VEC);
            $display("Checks failed");
            $fatal(1, "bad stimulus file");
        end

        // code_out zero on every reset edge
        for (int r = 0; r < RESET_CYCLES; r++) begin
            @(posedge clk);
            #1;
            compare_code_out('0, $sformatf("reset cycle %0d", r));
        end

        rst = 1'b0;
        exp_q.push_back('0);  // cleared stage-1 word shows on the first edge after reset
        apply_vector(0);

        // one new vector per cycle and the output lags by two edges
        for (int i = 1; i <= NUM_VEC + 1; i++) begin
            @(posedge clk);
            #1;
            if (i == 1) begin
                compare_code_out(exp_q.pop_front(), "first edge after reset");
            end else begin
                compare_code_out(exp_q.pop_front(), $sformatf("vector %0d", i - 2));
            end
            if (i < NUM_VEC) begin
                apply_vector(i);
            end else begin
                mode    = MODE_RSVD;  // idle once the file is used up
                info_in = '0;
            end
        end

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* test/secded_encoder_properties.sv */
`default_nettype none

`include "secded_params.svh"

// concurrent checks on the encoder top level
module secded_encoder_properties (
    input wire                              clk,
    input wire                              rst,
    input wire secded_types_pkg::mode_t     mode,
    input wire secded_types_pkg::codeword_t code_out
);
    timeunit 1ns;
    timeprecision 1ps;

    import secded_types_pkg::*;

    // overall parity makes every word even weight
    even_weight: assert property (
        @(posedge clk) disable iff (rst) (^code_out) == 1'b0
    ) else $error("code_out %h has odd weight", code_out);

    // reserved mode, zero word two edges later
    rsvd_zero: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst, 2) && $past(mode, 2) == MODE_RSVD) |-> code_out == '0
    ) else $error("code_out %h not zero for reserved mode", code_out);

    // (8,4) word fits in the low byte
    upper_clear_m0: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst, 2) && $past(mode, 2) == MODE_8_4)
            |-> code_out[`SECDED_CW_W-1:`SECDED_INFO_W0+`SECDED_PAR_W0] == '0
    ) else $error("code_out %h has bits above the (8,4) word", code_out);

    // (16,11) word fits in the low half
    upper_clear_m1: assert property (
        @(posedge clk) disable iff (rst)
        (!$past(rst, 2) && $past(mode, 2) == MODE_16_11)
            |-> code_out[`SECDED_CW_W-1:`SECDED_INFO_W1+`SECDED_PAR_W1] == '0
    ) else $error("code_out %h has bits above the (16,11) word", code_out);

endmodule

bind secded_encoder_top secded_encoder_properties props0 (
    .clk      (clk),
    .rst      (rst),
    .mode     (mode),
    .code_out (code_out)
);

`default_nettype wire

/* design/secded_encoder_top.sv */
`default_nettype none

// secded encoder, two stage pipeline
// code_out follows inputs sampled two edges earlier, new word every cycle
module secded_encoder_top (
    input  wire                          clk,
    input  wire                          rst,
    input  wire secded_types_pkg::info_t info_in,
    input  wire secded_types_pkg::mode_t mode,
    output secded_types_pkg::codeword_t  code_out
);
    import secded_types_pkg::*;

    codeword_t chk_word;  // stage 1 word, ovp slot zero
    mode_t     chk_mode;  // mode of that word

    // info placement and hamming checks
    enc_check_stage u_check (
        .clk      (clk),
        .rst      (rst),
        .info_in  (info_in),
        .mode     (mode),
        .chk_word (chk_word),
        .chk_mode (chk_mode)
    );

    // overall parity
    enc_parity_stage u_parity (
        .clk      (clk),
        .rst      (rst),
        .chk_word (chk_word),
        .chk_mode (chk_mode),
        .code_out (code_out)
    );

endmodule

`default_nettype wire

/* encoder/enc_parity_stage.sv */
`default_nettype none

// stage 2: overall parity over the stage-1 word, dropped into its slot
module enc_parity_stage (
    input  wire                              clk,
    input  wire                              rst,
    input  wire secded_types_pkg::codeword_t chk_word,
    input  wire secded_types_pkg::mode_t     chk_mode,
    output secded_types_pkg::codeword_t      code_out
);
    import secded_types_pkg::*;
    import secded_code_pkg::*;

    logic      ovp;     // overall parity bit
    codeword_t code_d;

    // the all-ones row of the check matrix is a plain xor reduce
    // ovp slot comes in as zero, so it does not bias the sum
    always_comb begin
        ovp = ^chk_word;
    end

    // insert at the top of the parity field for the carried mode
    // reserved mode: word is all zero, ovp is zero, slot 0 stays zero
    always_comb begin
        code_d = chk_word;
        code_d[ovp_index[chk_mode]] = ovp;
    end

    // output register, xor of code_out is zero once filled
    always_ff @(posedge clk) begin
        if (rst) begin
            code_out <= '0;
        end else begin
            code_out <= code_d;
        end
    end

endmodule

`default_nettype wire

/* encoder/enc_check_stage.sv */
`default_nettype none

`include "secded_params.svh"

// stage 1: place info over the parity field, fill in the hamming check bits
module enc_check_stage (
    input  wire                          clk,
    input  wire                          rst,
    input  wire secded_types_pkg::info_t info_in,
    input  wire secded_types_pkg::mode_t mode,
    output secded_types_pkg::codeword_t  chk_word,
    output secded_types_pkg::mode_t      chk_mode
);
    import secded_types_pkg::*;
    import secded_code_pkg::*;

    info_t     info_mask;  // keeps the low info_width bits
    codeword_t placed;     // info shifted up, parity field still clear
    h_rows_t   rows;       // check rows of the current mode
    parity_t   chk_bits;   // hamming checks, ovp slot left at zero
    codeword_t word_d;

    // row table for the current mode
    always_comb begin
        case (mode)
            MODE_8_4:   rows = h_rows_m0;
            MODE_16_11: rows = h_rows_m1;
            MODE_32_26: rows = h_rows_m2;
            default:    rows = '0;  // reserved
        endcase
    end

    // info placement
    always_comb begin
        // all ones below info_width, mode 2 wraps to all ones
        info_mask = ~(info_t'('1) << info_width[mode]);
        // unused upper info bits dropped before the shift
        placed = codeword_t'(info_in & info_mask) << parity_width[mode];
    end

    // check bits
    // row i is the xor of the info bits it selects
    // rows past the mode's check count are zero masks, so they give 0
    always_comb begin
        chk_bits = '0;
        for (int i = 0; i < `SECDED_PAR_W - 1; i++) begin
            chk_bits[i] = ^(rows[i] & placed);
        end
    end

    always_comb begin
        word_d = placed | codeword_t'(chk_bits);  // checks land in the low field
        if (mode == MODE_RSVD) begin
            word_d = '0;  // only place that looks at reserved mode
        end
    end

    // stage register, word and mode move together
    always_ff @(posedge clk) begin
        if (rst) begin
            chk_word <= '0;
            chk_mode <= '0;
        end else begin
            chk_word <= word_d;
            chk_mode <= mode;  // stage 2 needs it for the ovp slot
        end
    end

endmodule

`default_nettype wire

/* common/secded_code_pkg.sv */
`default_nettype none

`include "secded_params.svh"

package secded_code_pkg;
    import secded_types_pkg::*;

    // parity-check rows as masks over the padded codeword
    // each mask also covers its own check bit, which is still zero when used
    // first entry is row 4, last is row 0

    // (8,4): info [7:4], ovp bit 3, checks [2:0]
    localparam h_rows_t h_rows_m0 = {
        32'h0000_0000,  // no check bit 4
        32'h0000_0000,  // no check bit 3, slot holds ovp
        32'h0000_00e4,
        32'h0000_00d2,
        32'h0000_00b1
    };

    // (16,11): info [15:5], ovp bit 4, checks [3:0]
    localparam h_rows_t h_rows_m1 = {
        32'h0000_0000,  // bit 4 is ovp here
        32'h0000_fe08,
        32'h0000_f1c4,
        32'h0000_cda2,
        32'h0000_ab61
    };

    // (32,26): info [31:6], ovp bit 5, checks [4:0]
    localparam h_rows_t h_rows_m2 = {
        32'hfffe_0010,
        32'hff01_fc08,
        32'hf0f1_e384,
        32'hcccd_9b42,
        32'haaab_56c1
    };

    // layout per mode, reserved entries all zero
    localparam width_t info_width [0:3] = '{
        MODE_8_4:   width_t'(`SECDED_INFO_W0),
        MODE_16_11: width_t'(`SECDED_INFO_W1),
        MODE_32_26: width_t'(`SECDED_INFO_W2),
        MODE_RSVD:  width_t'(0)
    };

    localparam width_t parity_width [0:3] = '{
        MODE_8_4:   width_t'(`SECDED_PAR_W0),
        MODE_16_11: width_t'(`SECDED_PAR_W1),
        MODE_32_26: width_t'(`SECDED_PAR_W2),
        MODE_RSVD:  width_t'(0)
    };

    // overall parity sits on top of the parity field
    localparam bit_idx_t ovp_index [0:3] = '{
        MODE_8_4:   bit_idx_t'(`SECDED_PAR_W0 - 1),
        MODE_16_11: bit_idx_t'(`SECDED_PAR_W1 - 1),
        MODE_32_26: bit_idx_t'(`SECDED_PAR_W2 - 1),
        MODE_RSVD:  bit_idx_t'(0)  // word is zero anyway
    };

endpackage

`default_nettype wire

/* common/secded_types_pkg.sv */
`default_nettype none

`include "secded_params.svh"

package secded_types_pkg;

    // zero padded codeword, info above the parity field
    typedef logic [`SECDED_CW_W-1:0]   codeword_t;

    // info input, small modes only use the low bits
    typedef logic [`SECDED_INFO_W-1:0] info_t;

    typedef logic [`SECDED_PAR_W-1:0]  parity_t;   // low parity field of a codeword

    typedef logic [1:0]                mode_t;     // code size select

    typedef logic [5:0]                width_t;    // a field width, up to 32
    typedef logic [4:0]                bit_idx_t;  // a bit position in a codeword

    // one mask per hamming check bit, row i feeds check bit i
    // the all-ones row is left out, stage 2 does that one
    typedef codeword_t [`SECDED_PAR_W-2:0] h_rows_t;

    // mode encodings
    localparam mode_t MODE_8_4   = 2'd0;
    localparam mode_t MODE_16_11 = 2'd1;
    localparam mode_t MODE_32_26 = 2'd2;
    localparam mode_t MODE_RSVD  = 2'd3;  // reserved, all-zero word

endpackage

`default_nettype wire

/* common/secded_params.svh */
`ifndef SECDED_PARAMS_SVH
`define SECDED_PARAMS_SVH

// widths shared by the encoder stages and the packages

// padded codeword, every mode lands in this many bits
`define SECDED_CW_W     32

// widest info word, mode 2
`define SECDED_INFO_W   26

// widest parity field, check bits plus overall parity
`define SECDED_PAR_W    6

// info widths per mode
`define SECDED_INFO_W0  4   // (8,4)
`define SECDED_INFO_W1  11  // (16,11)
`define SECDED_INFO_W2  26  // (32,26)

// parity field widths per mode, top bit is the overall parity
`define SECDED_PAR_W0   4
`define SECDED_PAR_W1   5
`define SECDED_PAR_W2   6

`endif
